/* project.f */
+incdir+rtl
rtl/icache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

/* rtl/icache_ctrl.sv */
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
  input  wire logic                      clk,
  input  wire logic                      rst,
  // fetch side
  input  wire icache_pkg::icache_addr_t  fetch_addr_i,
  input  wire logic                      fetch_valid_i,
  output icache_pkg::fetch_rsp_t         fetch_rsp_o,
  // memory side
  output mem_bus_pkg::mem_rd_req_t       mem_req_o,
  output logic                           mem_req_valid_o,
  input  wire logic                      mem_rvalid_i,
  input  wire logic [`ICACHE_XLEN-1:0]   mem_rdata_i,
  // tag array
  input  wire logic                      hit_i,
  output logic                           tag_wr_o,
  // data array
  output icache_pkg::icache_addr_t       line_addr_o,
  output logic [`ICACHE_WSEL_W-1:0]      fill_word_o,
  output logic                           fill_we_o,
  output logic [`ICACHE_XLEN-1:0]        fill_data_o,
  input  wire logic [`ICACHE_XLEN-1:0]   cache_word_i
);

  import icache_pkg::*;
  import mem_bus_pkg::*;

  // control state
  icache_state_e state_q;
  logic          req_valid_q;
  logic [`ICACHE_WSEL_W-1:0] beat_q;

  // payload registers
  icache_addr_t  addr_q;
  mem_rd_req_t   req_q;
  logic [`ICACHE_XLEN-1:0] unc_data_q;

  logic uncached;
  logic beat_acc;
  logic last_beat;

  // device window lives in the top nibble of the tag
  assign uncached = (addr_q.tag[`ICACHE_TAG_W-1 -: 4] == `ICACHE_UNCACHED_WIN);

  // a beat only counts while a request is out
  assign beat_acc = req_valid_q & mem_rvalid_i;

  // single word read ends on its only beat
  assign last_beat = beat_acc &
                     ((state_q == UNCACHED_READ) |
                      (beat_q == `ICACHE_WSEL_W'(`ICACHE_WORDS_PER_LINE - 1)));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      req_valid_q <= 1'b0;
      beat_q      <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // new fetch only taken here
          if (fetch_valid_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (uncached) begin
            // bypass, one beat
            state_q     <= UNCACHED_READ;
            req_valid_q <= 1'b1;
          end else if (!hit_i) begin
            // miss, fetch the whole line
            state_q     <= REFILL;
            req_valid_q <= 1'b1;
            beat_q      <= '0;
          end else begin
            // hit answered this cycle
            state_q <= IDLE;
          end
        end
        REFILL: begin
          if (beat_acc) begin
            beat_q <= beat_q + 1'b1;
            // line complete, look up again and hit
            if (last_beat) begin
              req_valid_q <= 1'b0;
              state_q     <= LOOKUP;
            end
          end
        end
        UNCACHED_READ: begin
          if (beat_acc) begin
            req_valid_q <= 1'b0;
            state_q     <= RESPOND;
          end
        end
        RESPOND: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // capture the fetch address at acceptance
    if ((state_q == IDLE) && fetch_valid_i) begin
      addr_q <= fetch_addr_i;
    end
    // request built while leaving lookup
    if (state_q == LOOKUP) begin
      if (uncached) begin
        req_q.addr <= addr_q;
        req_q.len  <= 8'd0;
      end else begin
        // line aligned burst
        req_q.addr <= {addr_q.tag, addr_q.index, {`ICACHE_OFF_W{1'b0}}};
        req_q.len  <= 8'(`ICACHE_WORDS_PER_LINE - 1);
      end
    end
    // uncached word is held for the respond cycle
    if ((state_q == UNCACHED_READ) && beat_acc) begin
      unc_data_q <= mem_rdata_i;
    end
  end

  assign mem_req_o       = req_q;
  assign mem_req_valid_o = req_valid_q;

  // tag goes in at the same edge as the last word
  assign tag_wr_o = (state_q == REFILL) & last_beat;

  assign line_addr_o = addr_q;
  assign fill_we_o   = (state_q == REFILL) & mem_rvalid_i;
  assign fill_data_o = mem_rdata_i;

  // beat number during refill, else the word of the fetch
  assign fill_word_o = (state_q == REFILL) ? beat_q :
                       addr_q.offset[`ICACHE_OFF_W-1 -: `ICACHE_WSEL_W];

  // hit in lookup or the captured uncached word
  assign fetch_rsp_o.valid = ((state_q == LOOKUP) & hit_i & !uncached) |
                             (state_q == RESPOND);
  assign fetch_rsp_o.data  = (state_q == RESPOND) ? unc_data_q : cache_word_i;

  // memory is never busy while waiting for a fetch
  a_no_req_in_idle: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == IDLE) |-> !mem_req_valid_o
  );

  // request level held across beat gaps
  a_req_held: assert property (
    @(posedge clk) disable iff (rst)
    (mem_req_valid_o && !last_beat) |=> mem_req_valid_o
  );

  // response is a pulse
  a_rsp_pulse: assert property (
    @(posedge clk) disable iff (rst)
    fetch_rsp_o.valid |=> !fetch_rsp_o.valid
  );

endmodule

`default_nettype wire

/* rtl/icache_data_array.sv */
`default_nettype none

`include "icache_defines.svh"

module icache_data_array (
  input  wire logic                      clk,
  // line chosen by the index field
  input  wire icache_pkg::icache_addr_t  addr_i,
  // word within the line
  input  wire logic [`ICACHE_WSEL_W-1:0] word_sel_i,
  // one write per refill beat
  input  wire logic                      we_i,
  input  wire logic [`ICACHE_XLEN-1:0]   wdata_i,
  output logic [`ICACHE_XLEN-1:0]        rdata_o
);

  // flat word address, index then word number
  logic [`ICACHE_IDX_W+`ICACHE_WSEL_W-1:0] word_addr;

  // 2048 words of 32 bits
  logic [`ICACHE_XLEN-1:0] data_mem [`ICACHE_LINES * `ICACHE_WORDS_PER_LINE];

  assign word_addr = {addr_i.index, word_sel_i};

  // refill beat lands in its word slot
  always_ff @(posedge clk) begin
    if (we_i) begin
      data_mem[word_addr] <= wdata_i;
    end
  end

  // combinational read
  // same word as the write port
  assign rdata_o = data_mem[word_addr];

endmodule

`default_nettype wire

/* rtl/icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address and instruction word width
`define ICACHE_XLEN 32

// tag, index and byte offset widths of a fetch address
`define ICACHE_TAG_W 19
`define ICACHE_IDX_W 7
`define ICACHE_OFF_W 6

// 128 lines of 64 bytes
`define ICACHE_LINES 128

// words per line, also the refill beat count
`define ICACHE_WORDS_PER_LINE 16
`define ICACHE_WSEL_W 4

// top nibble of the uncached device window
`define ICACHE_UNCACHED_WIN 4'hA

`endif

/* rtl/icache_pkg.sv */
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  // fetch address split into its cache fields
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0] tag;
    logic [`ICACHE_IDX_W-1:0] index;
    logic [`ICACHE_OFF_W-1:0] offset;
  } icache_addr_t;

  // word back to the fetch unit
  // valid is a single cycle pulse
  typedef struct packed {
    logic                    valid;
    logic [`ICACHE_XLEN-1:0] data;
  } fetch_rsp_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED_READ,
    RESPOND
  } icache_state_e;

endpackage

`default_nettype wire

/* rtl/icache_tag_array.sv */
`default_nettype none

`include "icache_defines.svh"

module icache_tag_array (
  input  wire logic                     clk,
  input  wire logic                     rst,
  // registered fetch address from the controller
  input  wire icache_pkg::icache_addr_t addr_i,
  // pulse at the last refill beat
  input  wire logic                     tag_wr_i,
  output logic                          hit_o
);

  // one valid bit per line
  logic [`ICACHE_LINES-1:0] valid_q;

  // stored tag per line
  logic [`ICACHE_TAG_W-1:0] tag_mem [`ICACHE_LINES];

  // all lines invalid after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wr_i) begin
      // refilled line becomes valid
      valid_q[addr_i.index] <= 1'b1;
    end
  end

  // new tag replaces whatever line sat here before
  always_ff @(posedge clk) begin
    if (tag_wr_i) begin
      tag_mem[addr_i.index] <= addr_i.tag;
    end
  end

  // direct mapped, so one compare
  assign hit_o = valid_q[addr_i.index] & (tag_mem[addr_i.index] == addr_i.tag);

  // no refill can finish while the cache is held in reset
  a_no_tag_wr_in_rst: assert property (
    @(posedge clk) rst |-> !tag_wr_i
  );

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`default_nettype none

`include "icache_defines.svh"

module icache_top (
  input  wire logic                     clk,
  input  wire logic                     rst,
  // fetch unit
  input  wire icache_pkg::icache_addr_t fetch_addr_i,
  input  wire logic                     fetch_valid_i,
  output icache_pkg::fetch_rsp_t        fetch_rsp_o,
  // memory
  output mem_bus_pkg::mem_rd_req_t      mem_req_o,
  output logic                          mem_req_valid_o,
  input  wire logic                     mem_rvalid_i,
  input  wire logic [`ICACHE_XLEN-1:0]  mem_rdata_i
);

  import icache_pkg::*;

  // controller to arrays
  icache_addr_t line_addr;
  logic         tag_wr;
  logic         hit;
  logic [`ICACHE_WSEL_W-1:0] fill_word;
  logic         fill_we;
  logic [`ICACHE_XLEN-1:0] fill_data;
  logic [`ICACHE_XLEN-1:0] cache_word;

  icache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_rsp_o     (fetch_rsp_o),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i),
    .hit_i           (hit),
    .tag_wr_o        (tag_wr),
    .line_addr_o     (line_addr),
    .fill_word_o     (fill_word),
    .fill_we_o       (fill_we),
    .fill_data_o     (fill_data),
    .cache_word_i    (cache_word)
  );

  // valid bits and tags
  icache_tag_array u_tag_array (
    .clk      (clk),
    .rst      (rst),
    .addr_i   (line_addr),
    .tag_wr_i (tag_wr),
    .hit_o    (hit)
  );

  // instruction words
  icache_data_array u_data_array (
    .clk        (clk),
    .addr_i     (line_addr),
    .word_sel_i (fill_word),
    .we_i       (fill_we),
    .wdata_i    (fill_data),
    .rdata_o    (cache_word)
  );

endmodule

`default_nettype wire

/* rtl/mem_bus_pkg.sv */
`default_nettype none

`include "icache_defines.svh"

package mem_bus_pkg;

  // read request towards memory
  // len is beat count minus one
  // 15 for a line refill, 0 for a single word
  typedef struct packed {
    logic [`ICACHE_XLEN-1:0] addr;
    logic [7:0]              len;
  } mem_rd_req_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module icache_tb \
  -f project.f -o icache_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/icache_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/icache_tb.sv */
`default_nettype none

`include "icache_defines.svh"

module icache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import icache_pkg::*;
  import mem_bus_pkg::*;

  // access kinds as coded in the tests file
  localparam logic [31:0] KIND_NONE   = 32'd0;
  localparam logic [31:0] KIND_BURST  = 32'd1;
  localparam logic [31:0] KIND_SINGLE = 32'd2;
  localparam logic [31:0] KIND_END    = 32'd3;

  localparam int MAX_TESTS    = 64;
  localparam int RSP_TIMEOUT  = 400;
  localparam int RST_TIMEOUT  = 50;
  localparam int QUIET_CYCLES = 8;

  localparam logic [15:0] LFSR_SEED = 16'd35113;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;
  // memory word at address A is A xor this
  localparam logic [31:0] MEM_XOR   = 32'h5A5A_0000;
  localparam logic [31:0] LINE_MASK = ~((32'd1 << `ICACHE_OFF_W) - 32'd1);

  // one fetch from the tests file
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] kind;
  } test_vec_t;

  logic         clk;
  logic         rst;
  icache_addr_t fetch_addr;
  logic         fetch_valid;
  fetch_rsp_t   fetch_rsp;
  mem_rd_req_t  mem_req;
  logic         mem_req_valid;
  logic         mem_rvalid;
  logic [31:0]  mem_rdata;

  logic [15:0] lfsr_q;
  // requests seen by the memory model during one fetch
  logic [31:0] req_addr_log [$];
  logic [7:0]  req_len_log [$];
  // three words per test line
  logic [31:0] tests_raw [192];

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  icache_top dut (
    .clk             (clk),
    .rst             (rst),
    .fetch_addr_i    (fetch_addr),
    .fetch_valid_i   (fetch_valid),
    .fetch_rsp_o     (fetch_rsp),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_rvalid_i    (mem_rvalid),
    .mem_rdata_i     (mem_rdata)
  );

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ MEM_XOR;
  endfunction

  // galois lfsr, one step per bit taken
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // idle cycles before a beat, 0 to 3
  task automatic take_gap(output int gap);
    logic b0;
    logic b1;
    b0 = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    b1 = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    gap = {30'd0, b1, b0};
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("Test stopped: %s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped on a failure");
  endtask

  // memory model, sampled at falling edges, driven at rising edges
  initial begin : memory_model
    int          gap;
    logic [31:0] base;
    logic [7:0]  len;
    mem_rvalid <= 1'b0;
    mem_rdata  <= '0;
    lfsr_q = LFSR_SEED;
    forever begin
      @(negedge clk);
      if (!rst && mem_req_valid) begin
        base = mem_req.addr;
        len  = mem_req.len;
        req_addr_log.push_back(base);
        req_len_log.push_back(len);
        @(posedge clk);
        // beat k carries the word k places after the request address
        for (int k = 0; k <= int'(len); k++) begin
          take_gap(gap);
          mem_rvalid <= 1'b0;
          repeat (gap) @(posedge clk);
          mem_rvalid <= 1'b1;
          mem_rdata  <= mem_word(base + 32'(k) * 32'd4);
          @(posedge clk);
        end
        mem_rvalid <= 1'b0;
      end
    end
  end

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
      cycles++;
      if (rst && cycles >= RST_TIMEOUT) begin
        fail_run("reset was never released");
      end
    end
  endtask

  // nothing moves without a fetch
  task automatic check_quiet();
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_value({31'd0, fetch_rsp.valid}, 32'd0, "response valid while idle");
      check_value({31'd0, mem_req_valid}, 32'd0, "memory request while idle");
    end
  endtask

  task automatic run_fetch(input test_vec_t tv);
    int   cycles;
    logic rsp_seen;
    req_addr_log.delete();
    req_len_log.delete();
    @(posedge clk);
    fetch_addr  <= icache_addr_t'(tv.addr);
    fetch_valid <= 1'b1;
    cycles   = 0;
    rsp_seen = 1'b0;
    while (!rsp_seen) begin
      @(negedge clk);
      cycles++;
      if (fetch_rsp.valid) begin
        rsp_seen = 1'b1;
      end else if (cycles >= RSP_TIMEOUT) begin
        fail_run($sformatf("no fetch response for address %h", tv.addr));
      end
    end
    check_value(fetch_rsp.data, tv.word, "fetch word");
    check_value(fetch_rsp.data, mem_word(tv.addr), "fetch word against memory rule");
    // valid level drops at the edge that leaves the answering state
    @(posedge clk);
    fetch_valid <= 1'b0;
    case (tv.kind)
      KIND_NONE: begin
        check_value(32'(req_addr_log.size()), 32'd0, "memory requests on a hit");
        // acceptance edge plus one cycle of hit latency
        check_value(32'(cycles), 32'd2, "hit latency in cycles");
      end
      KIND_BURST: begin
        check_value(32'(req_addr_log.size()), 32'd1, "memory requests on a miss");
        check_value(req_addr_log[0], tv.addr & LINE_MASK, "refill address");
        check_value({24'd0, req_len_log[0]}, 32'(`ICACHE_WORDS_PER_LINE - 1), "refill length");
      end
      KIND_SINGLE: begin
        check_value(32'(req_addr_log.size()), 32'd1, "memory requests on uncached read");
        check_value(req_addr_log[0], tv.addr, "uncached address");
        check_value({24'd0, req_len_log[0]}, 32'd0, "uncached length");
      end
      default: begin
        fail_run($sformatf("unknown access kind %h in tests file", tv.kind));
      end
    endcase
  endtask

  initial begin : stimulus
    test_vec_t  tv;
    int         idx;
    logic [7:0] ridx;
    logic       done;
    fetch_valid <= 1'b0;
    fetch_addr  <= '0;
    $readmemh("verification/icache_tests.txt", tests_raw);
    wait_reset_release();
    check_quiet();
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx >= MAX_TESTS) begin
        fail_run("tests file has no end line");
      end else begin
        ridx = 8'(3 * idx);
        tv.addr = tests_raw[ridx];
        tv.word = tests_raw[ridx + 8'd1];
        tv.kind = tests_raw[ridx + 8'd2];
        if (tv.kind == KIND_END) begin
          done = 1'b1;
        end else begin
          run_fetch(tv);
          idx++;
        end
      end
    end
    if (idx == 0) begin
      fail_run("tests file holds no fetches");
    end else begin
      $display("%0d fetches checked", idx);
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/icache_tests.txt */
// columns: fetch address, expected word, access kind
// kind 0 = hit, 1 = line refill burst, 2 = uncached single, 3 = end of list
00001040 5A5A1040 1
00001044 5A5A1044 0
0000107C 5A5A107C 0
00001040 5A5A1040 0
A0000100 FA5A0100 2
A0000100 FA5A0100 2
A0000204 FA5A0204 2
00003040 5A5A3040 1
00003048 5A5A3048 0
00001040 5A5A1040 1
00001048 5A5A1048 0
00003040 5A5A3040 1
00012000 5A5B2000 1
0001203C 5A5B203C 0
80000FC0 DA5A0FC0 1
80000FC4 DA5A0FC4 0
00003044 5A5A3044 0
12345678 486E5678 1
1234567C 486E567C 0
00000000 00000000 3

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for the first 10 rising edges
  initial begin
    rst_o <= 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire
